// File: Makefile
TOP := tb_clint
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): project.f $(shell cat project.f)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); test $$rc -eq 0
	! grep -q '\*\*\* FAILED \*\*\*' $(LOG)

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir $(LOG)

// File: project.f
source/clint_pkg.sv
source/clint_axi_port.sv
source/clint_timer.sv
source/clint_regs.sv
source/clint.sv
test/clint_properties.sv
test/tb_clint.sv

// File: source/clint.sv
// clint top: AXI4 slave core-local interruptor with software and timer interrupts
`timescale 1ns/1ps

module clint #(
  parameter int AXI_ID_WIDTH   = 4,
  parameter int AXI_USER_WIDTH = 1,
  parameter int PRESCALE_WIDTH = 4
) (
  input  logic                               clk,
  input  logic                               rst,

  input  logic                               aw_valid_i,
  output logic                               aw_ready_o,
  input  logic [clint_pkg::ADDR_WIDTH-1:0]   aw_addr_i,
  input  logic [AXI_ID_WIDTH-1:0]            aw_id_i,
  input  logic [AXI_USER_WIDTH-1:0]          aw_user_i,

  input  logic                               w_valid_i,
  output logic                               w_ready_o,
  input  logic [clint_pkg::XLEN-1:0]         w_data_i,
  input  logic [clint_pkg::STRB_WIDTH-1:0]   w_strb_i,
  input  logic                               w_last_i,

  output logic                               b_valid_o,
  input  logic                               b_ready_i,
  output logic [1:0]                         b_resp_o,
  output logic [AXI_ID_WIDTH-1:0]            b_id_o,
  output logic [AXI_USER_WIDTH-1:0]          b_user_o,

  input  logic                               ar_valid_i,
  output logic                               ar_ready_o,
  input  logic [clint_pkg::ADDR_WIDTH-1:0]   ar_addr_i,
  input  logic [AXI_ID_WIDTH-1:0]            ar_id_i,
  input  logic [AXI_USER_WIDTH-1:0]          ar_user_i,

  output logic                               r_valid_o,
  input  logic                               r_ready_i,
  output logic [1:0]                         r_resp_o,
  output logic [clint_pkg::XLEN-1:0]         r_data_o,
  output logic                               r_last_o,
  output logic [AXI_ID_WIDTH-1:0]            r_id_o,
  output logic [AXI_USER_WIDTH-1:0]          r_user_o,

  output logic                               soft_irq_o,
  output logic                               timer_irq_o
);

  logic                              wr_en;
  logic [clint_pkg::ADDR_WIDTH-1:0]  wr_addr;
  logic [clint_pkg::XLEN-1:0]        wr_data;
  logic [clint_pkg::STRB_WIDTH-1:0]  wr_strb;
  logic [clint_pkg::ADDR_WIDTH-1:0]  rd_addr;
  logic [clint_pkg::XLEN-1:0]        rd_data;

  clint_axi_port #(
    .AXI_ID_WIDTH  (AXI_ID_WIDTH),
    .AXI_USER_WIDTH(AXI_USER_WIDTH)
  ) u_axi_port (
    .clk       (clk),
    .rst       (rst),
    .aw_valid_i(aw_valid_i),
    .aw_ready_o(aw_ready_o),
    .aw_addr_i (aw_addr_i),
    .aw_id_i   (aw_id_i),
    .aw_user_i (aw_user_i),
    .w_valid_i (w_valid_i),
    .w_ready_o (w_ready_o),
    .w_data_i  (w_data_i),
    .w_strb_i  (w_strb_i),
    .w_last_i  (w_last_i),
    .b_valid_o (b_valid_o),
    .b_ready_i (b_ready_i),
    .b_resp_o  (b_resp_o),
    .b_id_o    (b_id_o),
    .b_user_o  (b_user_o),
    .ar_valid_i(ar_valid_i),
    .ar_ready_o(ar_ready_o),
    .ar_addr_i (ar_addr_i),
    .ar_id_i   (ar_id_i),
    .ar_user_i (ar_user_i),
    .r_valid_o (r_valid_o),
    .r_ready_i (r_ready_i),
    .r_resp_o  (r_resp_o),
    .r_data_o  (r_data_o),
    .r_last_o  (r_last_o),
    .r_id_o    (r_id_o),
    .r_user_o  (r_user_o),
    .wr_en_o   (wr_en),
    .wr_addr_o (wr_addr),
    .wr_data_o (wr_data),
    .wr_strb_o (wr_strb),
    .rd_addr_o (rd_addr),
    .rd_data_i (rd_data)
  );

  clint_regs #(
    .PRESCALE_WIDTH(PRESCALE_WIDTH)
  ) u_regs (
    .clk        (clk),
    .rst        (rst),
    .wr_en_i    (wr_en),
    .wr_addr_i  (wr_addr),
    .wr_data_i  (wr_data),
    .wr_strb_i  (wr_strb),
    .rd_addr_i  (rd_addr),
    .rd_data_o  (rd_data),
    .soft_irq_o (soft_irq_o),
    .timer_irq_o(timer_irq_o)
  );

endmodule

// File: source/clint_axi_port.sv
// clint bus port: AXI4 slave read/write channel FSMs driving register access strobes
`timescale 1ns/1ps

module clint_axi_port #(
  parameter int AXI_ID_WIDTH   = 4,
  parameter int AXI_USER_WIDTH = 1
) (
  input  logic                               clk,
  input  logic                               rst,

  input  logic                               aw_valid_i,
  output logic                               aw_ready_o,
  input  logic [clint_pkg::ADDR_WIDTH-1:0]   aw_addr_i,
  input  logic [AXI_ID_WIDTH-1:0]            aw_id_i,
  input  logic [AXI_USER_WIDTH-1:0]          aw_user_i,

  input  logic                               w_valid_i,
  output logic                               w_ready_o,
  input  logic [clint_pkg::XLEN-1:0]         w_data_i,
  input  logic [clint_pkg::STRB_WIDTH-1:0]   w_strb_i,
  input  logic                               w_last_i,

  output logic                               b_valid_o,
  input  logic                               b_ready_i,
  output logic [1:0]                         b_resp_o,
  output logic [AXI_ID_WIDTH-1:0]            b_id_o,
  output logic [AXI_USER_WIDTH-1:0]          b_user_o,

  input  logic                               ar_valid_i,
  output logic                               ar_ready_o,
  input  logic [clint_pkg::ADDR_WIDTH-1:0]   ar_addr_i,
  input  logic [AXI_ID_WIDTH-1:0]            ar_id_i,
  input  logic [AXI_USER_WIDTH-1:0]          ar_user_i,

  output logic                               r_valid_o,
  input  logic                               r_ready_i,
  output logic [1:0]                         r_resp_o,
  output logic [clint_pkg::XLEN-1:0]         r_data_o,
  output logic                               r_last_o,
  output logic [AXI_ID_WIDTH-1:0]            r_id_o,
  output logic [AXI_USER_WIDTH-1:0]          r_user_o,

  output logic                               wr_en_o,
  output logic [clint_pkg::ADDR_WIDTH-1:0]   wr_addr_o,
  output logic [clint_pkg::XLEN-1:0]         wr_data_o,
  output logic [clint_pkg::STRB_WIDTH-1:0]   wr_strb_o,
  output logic [clint_pkg::ADDR_WIDTH-1:0]   rd_addr_o,
  input  logic [clint_pkg::XLEN-1:0]         rd_data_i
);

  typedef enum logic {R_IDLE, R_DATA} r_state_e;
  typedef enum logic [1:0] {W_IDLE, W_DATA, W_RESP} w_state_e;

  r_state_e                          r_state_q;
  w_state_e                          w_state_q;
  logic [clint_pkg::ADDR_WIDTH-1:0]  rd_addr_q;
  logic [AXI_ID_WIDTH-1:0]           rd_id_q;
  logic [AXI_USER_WIDTH-1:0]         rd_user_q;
  logic [clint_pkg::ADDR_WIDTH-1:0]  wr_addr_q;
  logic [AXI_ID_WIDTH-1:0]           wr_id_q;
  logic [AXI_USER_WIDTH-1:0]         wr_user_q;
  logic                              ar_hs;
  logic                              r_hs;
  logic                              aw_hs;
  logic                              w_hs;
  logic                              b_hs;

  assign ar_hs = ar_valid_i && ar_ready_o;
  assign r_hs  = r_valid_o && r_ready_i;
  assign aw_hs = aw_valid_i && aw_ready_o;
  assign w_hs  = w_valid_i && w_ready_o;
  assign b_hs  = b_valid_o && b_ready_i;

  // read channel
  always_ff @(posedge clk) begin
    if (rst) begin
      r_state_q <= R_IDLE;
      rd_addr_q <= '0;
      rd_id_q   <= '0;
      rd_user_q <= '0;
    end else begin
      case (r_state_q)
        R_IDLE: if (ar_hs) begin
          r_state_q <= R_DATA;
          rd_addr_q <= ar_addr_i;
          rd_id_q   <= ar_id_i;
          rd_user_q <= ar_user_i;
        end
        R_DATA: if (r_hs) begin
          r_state_q <= R_IDLE;
          rd_addr_q <= '0;
        end
        default: r_state_q <= R_IDLE;
      endcase
    end
  end

  assign ar_ready_o = (r_state_q == R_IDLE) && ar_valid_i;
  assign r_valid_o  = (r_state_q == R_DATA);
  // single beat, so every beat is the last
  assign r_last_o   = r_valid_o;
  assign r_resp_o   = clint_pkg::RESP_OKAY;
  assign r_data_o   = rd_data_i;
  assign r_id_o     = rd_id_q;
  assign r_user_o   = rd_user_q;
  assign rd_addr_o  = rd_addr_q;

  // write channel
  always_ff @(posedge clk) begin
    if (rst) begin
      w_state_q <= W_IDLE;
      wr_addr_q <= '0;
      wr_id_q   <= '0;
      wr_user_q <= '0;
    end else begin
      case (w_state_q)
        W_IDLE: if (aw_hs) begin
          w_state_q <= W_DATA;
          wr_addr_q <= aw_addr_i;
          wr_id_q   <= aw_id_i;
          wr_user_q <= aw_user_i;
        end
        W_DATA: if (w_hs) begin
          // later beats of a burst hit nothing
          wr_addr_q <= '0;
          if (w_last_i) begin
            w_state_q <= W_RESP;
          end
        end
        W_RESP: if (b_hs) begin
          w_state_q <= W_IDLE;
        end
        default: w_state_q <= W_IDLE;
      endcase
    end
  end

  assign aw_ready_o = (w_state_q == W_IDLE) && aw_valid_i;
  assign w_ready_o  = (w_state_q == W_DATA) && w_valid_i;
  assign b_valid_o  = (w_state_q == W_RESP);
  assign b_resp_o   = clint_pkg::RESP_OKAY;
  assign b_id_o     = wr_id_q;
  assign b_user_o   = wr_user_q;

  assign wr_en_o    = w_hs;
  assign wr_addr_o  = wr_addr_q;
  assign wr_data_o  = w_data_i;
  assign wr_strb_o  = w_strb_i;

endmodule

// File: source/clint_pkg.sv
// clint package: bus widths, register map and response codes for the CLINT

package clint_pkg;

  // one register word per bus beat
  localparam int XLEN       = 64;
  localparam int ADDR_WIDTH = 64;
  localparam int STRB_WIDTH = XLEN / 8;

  // register map for hart 0
  localparam logic [ADDR_WIDTH-1:0] MSIP_ADDR     = 64'h0000_0000_0200_0000;
  localparam logic [ADDR_WIDTH-1:0] MTIMECMP_ADDR = 64'h0000_0000_0200_4000;
  localparam logic [ADDR_WIDTH-1:0] MTIME_ADDR    = 64'h0000_0000_0200_BFF8;

  // every transfer is answered with OKAY
  localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

// File: source/clint_regs.sv
// clint register block: address decode, msip register and read data mux
`timescale 1ns/1ps

module clint_regs #(
  parameter int PRESCALE_WIDTH = 4
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               wr_en_i,
  input  logic [clint_pkg::ADDR_WIDTH-1:0]   wr_addr_i,
  input  logic [clint_pkg::XLEN-1:0]         wr_data_i,
  input  logic [clint_pkg::STRB_WIDTH-1:0]   wr_strb_i,
  input  logic [clint_pkg::ADDR_WIDTH-1:0]   rd_addr_i,
  output logic [clint_pkg::XLEN-1:0]         rd_data_o,
  output logic                               soft_irq_o,
  output logic                               timer_irq_o
);

  logic [clint_pkg::XLEN-1:0] wr_mask;
  logic [31:0]                msip_q;
  logic                       msip_we;
  logic                       mtime_we;
  logic                       mtimecmp_we;
  logic [clint_pkg::XLEN-1:0] mtime;
  logic [clint_pkg::XLEN-1:0] mtimecmp;

  // one mask byte per strobe
  always_comb begin
    for (int i = 0; i < clint_pkg::STRB_WIDTH; i++) begin
      wr_mask[8*i +: 8] = {8{wr_strb_i[i]}};
    end
  end

  assign msip_we     = wr_en_i && (wr_addr_i == clint_pkg::MSIP_ADDR);
  assign mtime_we    = wr_en_i && (wr_addr_i == clint_pkg::MTIME_ADDR);
  assign mtimecmp_we = wr_en_i && (wr_addr_i == clint_pkg::MTIMECMP_ADDR);

  // msip lives in the low word only
  always_ff @(posedge clk) begin
    if (rst) begin
      msip_q <= '0;
    end else if (msip_we) begin
      msip_q <= (msip_q & ~wr_mask[31:0]) | (wr_data_i[31:0] & wr_mask[31:0]);
    end
  end

  assign soft_irq_o = msip_q[0];

  clint_timer #(
    .PRESCALE_WIDTH(PRESCALE_WIDTH)
  ) u_timer (
    .clk          (clk),
    .rst          (rst),
    .mtime_we_i   (mtime_we),
    .mtimecmp_we_i(mtimecmp_we),
    .wr_data_i    (wr_data_i),
    .wr_mask_i    (wr_mask),
    .mtime_o      (mtime),
    .mtimecmp_o   (mtimecmp),
    .timer_irq_o  (timer_irq_o)
  );

  always_comb begin
    case (rd_addr_i)
      clint_pkg::MSIP_ADDR:     rd_data_o = {{(clint_pkg::XLEN-32){msip_q[31]}}, msip_q};
      clint_pkg::MTIMECMP_ADDR: rd_data_o = mtimecmp;
      clint_pkg::MTIME_ADDR:    rd_data_o = mtime;
      // unmapped reads as zero
      default:                  rd_data_o = '0;
    endcase
  end

endmodule

// File: source/clint_timer.sv
// clint machine timer: prescaled mtime counter, mtimecmp and timer interrupt compare
`timescale 1ns/1ps

module clint_timer #(
  parameter int PRESCALE_WIDTH = 4
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        mtime_we_i,
  input  logic                        mtimecmp_we_i,
  input  logic [clint_pkg::XLEN-1:0]  wr_data_i,
  input  logic [clint_pkg::XLEN-1:0]  wr_mask_i,
  output logic [clint_pkg::XLEN-1:0]  mtime_o,
  output logic [clint_pkg::XLEN-1:0]  mtimecmp_o,
  output logic                        timer_irq_o
);

  logic [PRESCALE_WIDTH-1:0]   prescale_q;
  logic                        tick;
  logic [clint_pkg::XLEN-1:0]  mtime_q;
  logic [clint_pkg::XLEN-1:0]  mtimecmp_q;

  // free-running divider, wraps on its own
  always_ff @(posedge clk) begin
    if (rst) begin
      prescale_q <= '0;
    end else begin
      prescale_q <= prescale_q + 1'b1;
    end
  end

  assign tick = &prescale_q;

  // a bus write beats the tick in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime_q <= '0;
    end else if (mtime_we_i) begin
      mtime_q <= (mtime_q & ~wr_mask_i) | (wr_data_i & wr_mask_i);
    end else if (tick) begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mtimecmp_q <= '0;
    end else if (mtimecmp_we_i) begin
      mtimecmp_q <= (mtimecmp_q & ~wr_mask_i) | (wr_data_i & wr_mask_i);
    end
  end

  assign mtime_o    = mtime_q;
  assign mtimecmp_o = mtimecmp_q;

  // unsigned compare, level held until mtimecmp moves ahead
  assign timer_irq_o = (mtime_q >= mtimecmp_q);

endmodule

// File: test/clint_properties.sv
// clint protocol checks: AXI valid hold, read last and write response exclusion
`timescale 1ns/1ps

module clint_properties (
  input logic clk,
  input logic rst,
  input logic aw_ready_i,
  input logic b_valid_i,
  input logic b_ready_i,
  input logic r_valid_i,
  input logic r_ready_i,
  input logic r_last_i
);

  b_valid_hold: assert property (@(posedge clk) disable iff (rst)
    b_valid_i && !b_ready_i |=> b_valid_i)
    else $error("b_valid_o dropped before b_ready_i");

  r_valid_hold: assert property (@(posedge clk) disable iff (rst)
    r_valid_i && !r_ready_i |=> r_valid_i)
    else $error("r_valid_o dropped before r_ready_i");

  // single beat reads
  r_last_on_valid: assert property (@(posedge clk) disable iff (rst)
    r_valid_i |-> r_last_i)
    else $error("r_last_o low during r_valid_o");

  b_aw_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(b_valid_i && aw_ready_i))
    else $error("aw_ready_o high while write response pending");

endmodule

bind clint clint_properties u_props (
  .clk       (clk),
  .rst       (rst),
  .aw_ready_i(aw_ready_o),
  .b_valid_i (b_valid_o),
  .b_ready_i (b_ready_i),
  .r_valid_i (r_valid_o),
  .r_ready_i (r_ready_i),
  .r_last_i  (r_last_o)
);

// File: test/tb_clint.sv
// clint testbench: directed AXI tests of msip, mtimecmp, mtime and both interrupts
`timescale 1ns/1ps

module tb_clint;

  localparam int ID_W       = 4;
  localparam int USER_W     = 1;
  localparam int MAX_CYCLES = 4000;
  localparam logic [63:0] UNMAPPED_ADDR = 64'h0000_0000_0200_1000;

  logic              clk;
  logic              rst;
  logic              aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, w_last_i;
  logic [63:0]       aw_addr_i, ar_addr_i, w_data_i, r_data_o;
  logic [ID_W-1:0]   aw_id_i, ar_id_i, b_id_o, r_id_o;
  logic [USER_W-1:0] aw_user_i, ar_user_i, b_user_o, r_user_o;
  logic [7:0]        w_strb_i;
  logic              b_valid_o, b_ready_i, ar_valid_i, ar_ready_o;
  logic              r_valid_o, r_ready_i, r_last_o;
  logic [1:0]        b_resp_o, r_resp_o;
  logic              soft_irq_o, timer_irq_o;

  int unsigned cycles     = 0;
  int          mismatches = 0;
  int          failures   = 0;
  logic [31:0] rng_state  = 32'h5aefdff0;

  clint u_dut (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic print_counts();
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
      failures = failures + 1;
      print_counts();
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic expect_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
      mismatches++;
    end
  endtask

  // outputs settle 1 ns after the falling edge
  task automatic wait_sample();
    @(negedge clk);
    #1;
  endtask

  task automatic axi_write(input logic [63:0] addr, input logic [63:0] data,
                           input logic [7:0] strb, input int hold);
    logic [31:0] rnd;
    rnd = next_random();
    @(negedge clk);
    aw_valid_i = 1'b1;
    aw_addr_i  = addr;
    aw_id_i    = rnd[ID_W-1:0];
    aw_user_i  = rnd[8 +: USER_W];
    #1;
    while (!aw_ready_o) wait_sample();
    @(negedge clk);
    aw_valid_i = 1'b0;
    w_valid_i  = 1'b1;
    w_data_i   = data;
    w_strb_i   = strb;
    w_last_i   = 1'b1;
    #1;
    while (!w_ready_o) wait_sample();
    @(negedge clk);
    w_valid_i = 1'b0;
    w_last_i  = 1'b0;
    #1;
    while (!b_valid_o) wait_sample();
    repeat (hold) begin
      wait_sample();
      if (!b_valid_o) begin
        $display("write response withdrawn before b_ready_i at %0t", $time);
        failures++;
      end
      expect_eq("held b_id", b_id_o, rnd[ID_W-1:0]);
    end
    @(negedge clk);
    b_ready_i = 1'b1;
    #1;
    expect_eq("b_resp", b_resp_o, clint_pkg::RESP_OKAY);
    expect_eq("b_id", b_id_o, rnd[ID_W-1:0]);
    expect_eq("b_user", b_user_o, rnd[8 +: USER_W]);
    @(negedge clk);
    b_ready_i = 1'b0;
  endtask

  task automatic axi_read(input logic [63:0] addr, input int hold, output logic [63:0] data);
    logic [31:0] rnd;
    logic [63:0] first;
    rnd = next_random();
    @(negedge clk);
    ar_valid_i = 1'b1;
    ar_addr_i  = addr;
    ar_id_i    = rnd[ID_W-1:0];
    ar_user_i  = rnd[8 +: USER_W];
    #1;
    while (!ar_ready_o) wait_sample();
    @(negedge clk);
    ar_valid_i = 1'b0;
    #1;
    while (!r_valid_o) wait_sample();
    first = r_data_o;
    repeat (hold) begin
      wait_sample();
      if (!r_valid_o) begin
        $display("read data withdrawn before r_ready_i at %0t", $time);
        failures++;
      end
      expect_eq("held r_id", r_id_o, rnd[ID_W-1:0]);
      // mtime keeps counting underneath a held read
      if (addr != clint_pkg::MTIME_ADDR) expect_eq("held r_data", r_data_o, first);
    end
    @(negedge clk);
    r_ready_i = 1'b1;
    #1;
    data = r_data_o;
    expect_eq("r_resp", r_resp_o, clint_pkg::RESP_OKAY);
    expect_eq("r_id", r_id_o, rnd[ID_W-1:0]);
    expect_eq("r_user", r_user_o, rnd[8 +: USER_W]);
    expect_eq("r_last", r_last_o, 1'b1);
    @(negedge clk);
    r_ready_i = 1'b0;
  endtask

  task automatic test_reset_state();
    logic [63:0] rd;
    expect_eq("soft_irq after reset", soft_irq_o, 1'b0);
    expect_eq("timer_irq after reset", timer_irq_o, 1'b1);
    axi_read(clint_pkg::MSIP_ADDR, 0, rd);
    expect_eq("msip after reset", rd, 64'h0);
    axi_read(clint_pkg::MTIMECMP_ADDR, 0, rd);
    expect_eq("mtimecmp after reset", rd, 64'h0);
    axi_read(UNMAPPED_ADDR, 0, rd);
    expect_eq("unmapped read", rd, 64'h0);
    axi_read(clint_pkg::MTIME_ADDR, 0, rd);
    if (rd > 64'(cycles / 16 + 1)) begin
      $display("MISMATCH at %0t: mtime %0d ahead of %0d cycles", $time, rd, cycles);
      mismatches++;
    end
  endtask

  task automatic test_soft_irq();
    logic [63:0] rd;
    axi_write(clint_pkg::MSIP_ADDR, 64'h1, 8'hFF, 0);
    expect_eq("soft_irq after msip set", soft_irq_o, 1'b1);
    axi_read(clint_pkg::MSIP_ADDR, 0, rd);
    expect_eq("msip readback", rd, 64'h1);
    axi_write(clint_pkg::MSIP_ADDR, 64'h8000_0001, 8'hFF, 0);
    axi_read(clint_pkg::MSIP_ADDR, 0, rd);
    expect_eq("msip sign extension", rd, 64'hFFFF_FFFF_8000_0001);
    axi_write(clint_pkg::MSIP_ADDR, 64'h0, 8'hFF, 0);
    expect_eq("soft_irq after msip clear", soft_irq_o, 1'b0);
  endtask

  task automatic test_strobe_merge();
    logic [63:0] a, b, exp, rd;
    logic [31:0] rnd;
    a   = {next_random(), next_random()};
    b   = {next_random(), next_random()};
    rnd = next_random();
    for (int i = 0; i < 8; i++) exp[8*i +: 8] = rnd[i] ? b[8*i +: 8] : a[8*i +: 8];
    axi_write(clint_pkg::MTIMECMP_ADDR, a, 8'hFF, 0);
    axi_write(clint_pkg::MTIMECMP_ADDR, b, rnd[7:0], 0);
    axi_read(clint_pkg::MTIMECMP_ADDR, 0, rd);
    expect_eq("mtimecmp strobe merge", rd, exp);
  endtask

  task automatic test_timer();
    logic [63:0] m1, m2, m3;
    longint unsigned c1, c2, ticks, delta;
    int waited;
    axi_write(clint_pkg::MTIME_ADDR, {32'h0, next_random()}, 8'hFF, 0);
    axi_write(clint_pkg::MTIMECMP_ADDR, 64'h0000_0100_0000_0000, 8'hFF, 0);
    expect_eq("timer_irq below mtimecmp", timer_irq_o, 1'b0);
    axi_read(clint_pkg::MTIME_ADDR, 0, m1);
    c1 = cycles;
    repeat (200) @(negedge clk);
    axi_read(clint_pkg::MTIME_ADDR, 0, m2);
    c2 = cycles;
    ticks = (c2 - c1) / 16;
    delta = m2 - m1;
    if (delta + 1 < ticks || delta > ticks + 1) begin
      $display("MISMATCH at %0t: mtime moved %0d over %0d cycles", $time, delta, c2 - c1);
      mismatches++;
    end
    axi_write(clint_pkg::MTIMECMP_ADDR, m2 + 3, 8'hFF, 0);
    waited = 0;
    while (!timer_irq_o && waited < 100) begin
      wait_sample();
      waited++;
    end
    if (!timer_irq_o) begin
      $display("timer interrupt did not rise within 100 cycles");
      failures++;
    end
    axi_read(clint_pkg::MTIME_ADDR, 0, m3);
    if (m3 < m2 + 3) begin
      $display("MISMATCH at %0t: mtime %0d below mtimecmp %0d", $time, m3, m2 + 3);
      mismatches++;
    end
  endtask

  task automatic test_backpressure();
    logic [63:0] wdata, rdata;
    logic [31:0] msip_val;
    int hw, hr;
    repeat (4) begin
      wdata    = {next_random(), next_random()};
      msip_val = next_random();
      hw       = 1 + int'(next_random() % 5);
      hr       = 1 + int'(next_random() % 5);
      // nonzero msip so a held read has data worth watching
      axi_write(clint_pkg::MSIP_ADDR, {32'h0, msip_val}, 8'hFF, 0);
      // write and read in flight together
      fork
        axi_write(clint_pkg::MTIMECMP_ADDR, wdata, 8'hFF, hw);
        axi_read(clint_pkg::MSIP_ADDR, hr, rdata);
      join
      expect_eq("msip during parallel write", rdata, {{32{msip_val[31]}}, msip_val});
      axi_read(clint_pkg::MTIMECMP_ADDR, 0, rdata);
      expect_eq("mtimecmp after parallel write", rdata, wdata);
    end
  endtask

  initial begin
    rst        = 1'b1;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    aw_id_i    = '0;
    aw_user_i  = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    w_last_i   = 1'b0;
    b_ready_i  = 1'b0;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    ar_id_i    = '0;
    ar_user_i  = '0;
    r_ready_i  = 1'b0;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    #1;
    test_reset_state();
    test_soft_irq();
    test_strobe_merge();
    test_timer();
    test_backpressure();
    print_counts();
    if (mismatches == 0 && failures == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
